/* src.f */
hl2_ctrl_pkg.sv
cmd_toggle_rx.sv
tx_keying.sv
rx_status.sv
resp_builder.sv
hl2_ctrl_core.sv
tb_checker.sv
tb_hl2_ctrl_core.sv

/* Makefile */
# Verilator build and run of the control core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
	  --top-module tb_hl2_ctrl_core -f src.f -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_hl2_ctrl_core.sv */
// testbench top that drives random commands and levels into the control core and prints the verdict
`timescale 1ns/10ps

module tb_hl2_ctrl_core
  import hl2_ctrl_pkg::*;
();

  logic   clk_ctrl;
  logic   rst_n;
  cmd_t   cmd;
  logic   cmd_cnt;
  logic   rxclip;
  logic   rxgoodlvl;
  logic   io_tx_inhibit;
  logic   tx_on;
  resp_t  resp;
  logic   resp_valid;
  integer seed;
  integer clip_left;
  integer gap;
  integer n;
  bit     timed_out;

  hl2_ctrl_core dut0 (
    .clk_ctrl        (clk_ctrl     ),
    .rst_n_i         (rst_n        ),
    .cmd_i           (cmd          ),
    .cmd_cnt_i       (cmd_cnt      ),
    .rxclip_i        (rxclip       ),
    .rxgoodlvl_i     (rxgoodlvl    ),
    .io_tx_inhibit_i (io_tx_inhibit),
    .tx_on_o         (tx_on        ),
    .resp_o          (resp         ),
    .resp_valid_o    (resp_valid   )
  );

  tb_checker chk0 (
    .clk_ctrl     (clk_ctrl  ),
    .rst_n_i      (rst_n     ),
    .tx_on_i      (tx_on     ),
    .resp_i       (resp      ),
    .resp_valid_i (resp_valid)
  );

  always #10 clk_ctrl = ~clk_ctrl;

  ////////////////////////////////////////
  // stimulus helpers

  // one falling edge plus a step of the clip pulse generator
  task automatic tick();
    @(negedge clk_ctrl);
    if (clip_left > 0) begin
      clip_left = clip_left - 1;
    end else if (rxclip) begin
      rxclip    = 1'b0;
      clip_left = 2 + ($unsigned($random(seed)) % 8);
    end else begin
      rxclip    = 1'b1;
      clip_left = 2 + ($unsigned($random(seed)) % 4);
    end
  endtask

  task automatic send_command();
    logic [31:0] r;
    integer      kind;
    kind         = $unsigned($random(seed)) % 3;
    r            = $random(seed);
    cmd.data     = $random(seed);
    cmd.resprqst = r[8];
    if (kind == 0) begin
      cmd.addr = ADDR_KEYING;
    end else if (kind == 1) begin
      cmd.addr = ADDR_CLR_STATUS;
    end else begin
      cmd.addr = r[5:0];
      if (cmd.addr == ADDR_KEYING || cmd.addr == ADDR_CLR_STATUS) begin
        cmd.addr = 6'h15;
      end
    end
    cmd_cnt = ~cmd_cnt;
  endtask

  task automatic wait_response();
    integer waited;
    waited = 0;
    while (!resp_valid && waited < 12) begin
      tick();
      waited = waited + 1;
    end
    if (!resp_valid) begin
      $display("timeout, no response within 12 cycles of command %0d", n);
      timed_out = 1'b1;
    end
  endtask

  task automatic change_levels();
    if (($random(seed) & 3) == 0) begin
      io_tx_inhibit = ~io_tx_inhibit;
    end
    if (($random(seed) & 3) == 0) begin
      rxgoodlvl = ~rxgoodlvl;
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    seed          = 32'he105a8c9;
    clk_ctrl      = 1'b0;
    rst_n         = 1'b0;
    cmd           = '0;
    cmd_cnt       = 1'b0;
    rxclip        = 1'b0;
    rxgoodlvl     = 1'b0;
    io_tx_inhibit = 1'b0;
    clip_left     = 0;
    timed_out     = 1'b0;
    repeat (16) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    rst_n = 1'b1;
    repeat (8) tick();
    for (n = 0; n < 200 && !timed_out; n = n + 1) begin
      send_command();
      if (cmd.resprqst) begin
        wait_response();
        repeat (2) tick();
      end else begin
        repeat (7) tick();
      end
      // new levels stay put for the rest of the gap
      change_levels();
      gap = 4 + ($unsigned($random(seed)) % 12);
      // one long idle stretch so the clip counter reaches saturation
      if (n == 100) begin
        gap = gap + 4200;
      end
      repeat (gap) tick();
    end
    $display("checks %0d errors %0d timeouts %0d", chk0.check_count, chk0.err_count,
             timed_out);
    if (chk0.err_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb_checker.sv */
// testbench model and comparator, tracks keying and receive status and checks every DUT output
`timescale 1ns/10ps

module tb_checker
  import hl2_ctrl_pkg::*;
(
  input logic  clk_ctrl,
  input logic  rst_n_i,
  input logic  tx_on_i,
  input resp_t resp_i,
  input logic  resp_valid_i
);

  int         err_count;
  int         check_count;
  int         edge_no;
  int         inh_stable;
  logic       cnt_prev;
  cmd_t       cmd_m;
  logic       mox_m;
  logic       cw_m;
  logic       clip_seen_m;
  logic       good_seen_m;
  clip_cnt_t  clip_cnt_m;
  // input samples of the last edges, index 0 is the most recent
  logic [2:0] clip_h;
  logic [1:0] good_h;
  logic [1:0] inh_h;
  resp_t      exp_resp;

  task automatic compare_field(input string name, input logic [39:0] exp_v,
                               input logic [39:0] act_v);
    check_count = check_count + 1;
    if (exp_v !== act_v) begin
      err_count = err_count + 1;
      $display("ERR %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  ////////////////////////////////////////
  // model, stepped on every rising edge

  always @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      edge_no     = 0;
      inh_stable  = 0;
      cnt_prev    = 1'b0;
      mox_m       = 1'b0;
      cw_m        = 1'b0;
      clip_seen_m = 1'b0;
      good_seen_m = 1'b0;
      clip_cnt_m  = '0;
      clip_h      = '0;
      good_h      = '0;
      inh_h       = '0;
    end else begin
      if (edge_no != 0 && edge_no < 1000) begin
        edge_no = edge_no + 1;
      end
      // edge 1 is the one that first samples the toggle
      if (tb_hl2_ctrl_core.cmd_cnt != cnt_prev) begin
        edge_no = 1;
        cmd_m   = tb_hl2_ctrl_core.cmd;
      end
      cnt_prev = tb_hl2_ctrl_core.cmd_cnt;
      // response captures the state left by edge 4
      if (edge_no == 5) begin
        exp_resp.addr  = cmd_m.addr;
        exp_resp.tx_on = mox_m & ~inh_h[1];
        exp_resp.cw_on = mox_m & ~inh_h[1] & cw_m;
        exp_resp.data  = {clip_cnt_m, clip_seen_m, good_seen_m, mox_m & inh_h[1], 5'b00000,
                          VERSION_MINOR, VERSION_MAJOR};
      end
      if (edge_no == 4 && cmd_m.addr == ADDR_KEYING) begin
        mox_m = cmd_m.data[0];
        cw_m  = cmd_m.data[1];
      end
      if (edge_no == 4 && cmd_m.addr == ADDR_CLR_STATUS) begin
        clip_seen_m = 1'b0;
        good_seen_m = 1'b0;
        clip_cnt_m  = '0;
      end else begin
        clip_seen_m = clip_seen_m | clip_h[1];
        good_seen_m = good_seen_m | good_h[1];
        if (clip_h[1] && !clip_h[2] && clip_cnt_m != 8'd255) begin
          clip_cnt_m = clip_cnt_m + 8'd1;
        end
      end
      if (tb_hl2_ctrl_core.io_tx_inhibit != inh_h[0]) begin
        inh_stable = 0;
      end else if (inh_stable < 100) begin
        inh_stable = inh_stable + 1;
      end
      clip_h = {clip_h[1:0], tb_hl2_ctrl_core.rxclip};
      good_h = {good_h[0], tb_hl2_ctrl_core.rxgoodlvl};
      inh_h  = {inh_h[0], tb_hl2_ctrl_core.io_tx_inhibit};
    end
  end

  ////////////////////////////////////////
  // compare on falling edges, outputs are settled

  always @(negedge clk_ctrl) begin
    if (!rst_n_i) begin
      compare_field("reset_tx_on", 40'd0, 40'(tx_on_i));
      compare_field("reset_resp_valid", 40'd0, 40'(resp_valid_i));
    end else begin
      compare_field("resp_valid", 40'(edge_no == 5 && cmd_m.resprqst), 40'(resp_valid_i));
      if (edge_no == 5 && cmd_m.resprqst && resp_valid_i) begin
        compare_field("resp_addr", 40'(exp_resp.addr), 40'(resp_i.addr));
        compare_field("version", 40'(exp_resp.data[15:0]), 40'(resp_i.data[15:0]));
        compare_field("keying", 40'({exp_resp.tx_on, exp_resp.cw_on}),
                      40'({resp_i.tx_on, resp_i.cw_on}));
        compare_field("inhibit", 40'(exp_resp.data[21]), 40'(resp_i.data[21]));
        compare_field("sticky_flags", 40'(exp_resp.data[23:22]), 40'(resp_i.data[23:22]));
        compare_field("spare_zero", 40'(exp_resp.data[20:16]), 40'(resp_i.data[20:16]));
        compare_field("clip_count", 40'(exp_resp.data[31:24]), 40'(resp_i.data[31:24]));
      end
      // keying output once inhibit and MOX have settled
      if (inh_stable >= 4 && (edge_no == 0 || edge_no >= 6)) begin
        compare_field("tx_on_o", 40'(mox_m & ~inh_h[1]), 40'(tx_on_i));
      end
    end
  end

endmodule

/* hl2_ctrl_core.sv */
// control block top, receiver feeding keying and receive status in parallel, then the response builder
`timescale 1ns/10ps

module hl2_ctrl_core
  import hl2_ctrl_pkg::*;
(
  input  logic  clk_ctrl,
  input  logic  rst_n_i,
  input  cmd_t  cmd_i,
  input  logic  cmd_cnt_i,
  input  logic  rxclip_i,
  input  logic  rxgoodlvl_i,
  input  logic  io_tx_inhibit_i,
  output logic  tx_on_o,
  output resp_t resp_o,
  output logic  resp_valid_o
);

  cmd_strobe_t cmd_stb;
  tx_state_t   tx_state;
  rx_state_t   rx_state;

  cmd_toggle_rx cmd_toggle_rx0 (
    .clk_ctrl  (clk_ctrl ),
    .rst_n_i   (rst_n_i  ),
    .cmd_i     (cmd_i    ),
    .cmd_cnt_i (cmd_cnt_i),
    .cmd_stb_o (cmd_stb  )
  );

  // keying and status run side by side on the same strobe
  tx_keying tx_keying0 (
    .clk_ctrl        (clk_ctrl       ),
    .rst_n_i         (rst_n_i        ),
    .cmd_stb_i       (cmd_stb        ),
    .io_tx_inhibit_i (io_tx_inhibit_i),
    .tx_state_o      (tx_state       )
  );

  rx_status rx_status0 (
    .clk_ctrl    (clk_ctrl   ),
    .rst_n_i     (rst_n_i    ),
    .cmd_stb_i   (cmd_stb    ),
    .rxclip_i    (rxclip_i   ),
    .rxgoodlvl_i (rxgoodlvl_i),
    .rx_state_o  (rx_state   )
  );

  resp_builder resp_builder0 (
    .clk_ctrl     (clk_ctrl    ),
    .rst_n_i      (rst_n_i     ),
    .cmd_stb_i    (cmd_stb     ),
    .tx_state_i   (tx_state    ),
    .rx_state_i   (rx_state    ),
    .resp_o       (resp_o      ),
    .resp_valid_o (resp_valid_o)
  );

  assign tx_on_o = tx_state.tx_on;

endmodule

/* resp_builder.sv */
// response builder that packs keying and receive status into the 40-bit response
`timescale 1ns/10ps

module resp_builder
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  input  cmd_strobe_t cmd_stb_i,
  input  tx_state_t   tx_state_i,
  input  rx_state_t   rx_state_i,
  output resp_t       resp_o,
  output logic        resp_valid_o
);

  logic      pend_q;
  cmd_addr_t pend_addr;
  logic      resp_valid_q;
  resp_t     resp_q;
  cmd_data_t resp_data;

  ////////////////////////////////////////
  // response word layout

  // clip count, status bits, spare zeros, version
  assign resp_data = {rx_state_i.clip_count,
                      rx_state_i.clip_seen,
                      rx_state_i.goodlvl_seen,
                      tx_state_i.inhibited,
                      5'b00000,
                      VERSION_MINOR,
                      VERSION_MAJOR};

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      // one cycle wait so keying and status have applied the command
      pend_q       <= cmd_stb_i.valid & cmd_stb_i.cmd.resprqst;
      resp_valid_q <= pend_q;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd_stb_i.valid) begin
      pend_addr <= cmd_stb_i.cmd.addr;
    end
    if (pend_q) begin
      resp_q.addr  <= pend_addr;
      resp_q.tx_on <= tx_state_i.tx_on;
      resp_q.cw_on <= tx_state_i.cw_on;
      resp_q.data  <= resp_data;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

/* rx_status.sv */
// receive status, sticky ADC clip and good-level flags with a saturating clip event counter
`timescale 1ns/10ps

module rx_status
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  input  cmd_strobe_t cmd_stb_i,
  input  logic        rxclip_i,
  input  logic        rxgoodlvl_i,
  output rx_state_t   rx_state_o
);

  logic      clip_meta;
  logic      clip_sync;
  logic      clip_last;
  logic      good_meta;
  logic      good_sync;
  logic      clip_seen_q;
  logic      good_seen_q;
  clip_cnt_t clip_cnt_q;
  logic      clr_cmd;
  logic      clip_rise;

  assign clr_cmd   = cmd_stb_i.valid && (cmd_stb_i.cmd.addr == ADDR_CLR_STATUS);
  assign clip_rise = clip_sync & ~clip_last;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clip_meta   <= 1'b0;
      clip_sync   <= 1'b0;
      clip_last   <= 1'b0;
      good_meta   <= 1'b0;
      good_sync   <= 1'b0;
      clip_seen_q <= 1'b0;
      good_seen_q <= 1'b0;
      clip_cnt_q  <= '0;
    end else begin
      clip_meta <= rxclip_i;
      clip_sync <= clip_meta;
      clip_last <= clip_sync;
      good_meta <= rxgoodlvl_i;
      good_sync <= good_meta;
      // clear beats a clip edge on the same cycle
      if (clr_cmd) begin
        clip_seen_q <= 1'b0;
        good_seen_q <= 1'b0;
        clip_cnt_q  <= '0;
      end else begin
        clip_seen_q <= clip_seen_q | clip_sync;
        good_seen_q <= good_seen_q | good_sync;
        if (clip_rise && (clip_cnt_q != CLIP_CNT_MAX)) begin
          clip_cnt_q <= clip_cnt_q + 1'b1;
        end
      end
    end
  end

  assign rx_state_o.clip_seen    = clip_seen_q;
  assign rx_state_o.goodlvl_seen = good_seen_q;
  assign rx_state_o.clip_count   = clip_cnt_q;

endmodule

/* tx_keying.sv */
// transmit keying that holds MOX and CW mode from keying commands and gates them with TX inhibit
`timescale 1ns/10ps

module tx_keying
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  input  cmd_strobe_t cmd_stb_i,
  input  logic        io_tx_inhibit_i,
  output tx_state_t   tx_state_o
);

  logic      mox_q;
  logic      cw_mode_q;
  logic      inh_meta;
  logic      inh_sync;
  logic      keying_cmd;
  tx_state_t tx_state;

  assign keying_cmd = cmd_stb_i.valid && (cmd_stb_i.cmd.addr == ADDR_KEYING);

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mox_q     <= 1'b0;
      cw_mode_q <= 1'b0;
      inh_meta  <= 1'b0;
      inh_sync  <= 1'b0;
    end else begin
      // external inhibit is asynchronous
      inh_meta <= io_tx_inhibit_i;
      inh_sync <= inh_meta;
      if (keying_cmd) begin
        mox_q     <= cmd_stb_i.cmd.data[0];
        cw_mode_q <= cmd_stb_i.cmd.data[1];
      end
    end
  end

  ////////////////////////////////////////
  // keying outputs

  assign tx_state.tx_on     = mox_q & ~inh_sync;
  // CW only while actually transmitting
  assign tx_state.cw_on     = mox_q & ~inh_sync & cw_mode_q;
  assign tx_state.inhibited = mox_q & inh_sync;

  assign tx_state_o = tx_state;

  ////////////////////////////////////////
  // assertions

  a_cw_needs_tx: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    tx_state.cw_on |-> tx_state.tx_on
  );

endmodule

/* cmd_toggle_rx.sv */
// command receiver, turns each toggle of the command count into a one-cycle strobe with fields
`timescale 1ns/10ps

module cmd_toggle_rx
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        rst_n_i,
  input  cmd_t        cmd_i,
  input  logic        cmd_cnt_i,
  output cmd_strobe_t cmd_stb_o
);

  // two-flop synchronizer plus last seen value
  logic cnt_meta;
  logic cnt_sync;
  logic cnt_last;
  logic cnt_change;
  logic stb_valid;
  cmd_t cmd_q;

  assign cnt_change = cnt_sync ^ cnt_last;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_meta  <= 1'b0;
      cnt_sync  <= 1'b0;
      cnt_last  <= 1'b0;
      stb_valid <= 1'b0;
    end else begin
      cnt_meta  <= cmd_cnt_i;
      cnt_sync  <= cnt_meta;
      cnt_last  <= cnt_sync;
      // third edge after the toggle is sampled
      stb_valid <= cnt_change;
    end
  end

  // fields are held stable by the sender, capture with the strobe
  always_ff @(posedge clk_ctrl) begin
    if (cnt_change) begin
      cmd_q <= cmd_i;
    end
  end

  assign cmd_stb_o.valid = stb_valid;
  assign cmd_stb_o.cmd   = cmd_q;

  ////////////////////////////////////////
  // assertions

  // strobe is a single pulse, commands are spaced apart
  a_stb_single: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    stb_valid |=> !stb_valid
  );

endmodule

/* hl2_ctrl_pkg.sv */
// shared widths, command addresses, version constants and structs, imported by every RTL block
package hl2_ctrl_pkg;

  ////////////////////////////////////////
  // widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int CLIP_CNT_W = 8;

  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [CMD_DATA_W-1:0] cmd_data_t;
  typedef logic [CLIP_CNT_W-1:0] clip_cnt_t;

  ////////////////////////////////////////
  // command addresses and constants

  // data bit 0 is MOX, data bit 1 is CW mode
  localparam cmd_addr_t ADDR_KEYING     = 6'h00;
  // clears the sticky receive status
  localparam cmd_addr_t ADDR_CLR_STATUS = 6'h3a;

  localparam logic [7:0] VERSION_MAJOR = 8'd72;
  localparam logic [7:0] VERSION_MINOR = 8'd4;

  // clip counter saturates here
  localparam clip_cnt_t CLIP_CNT_MAX = 8'd255;

  ////////////////////////////////////////
  // structs

  // held command fields, 39 bits
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      resprqst;
  } cmd_t;

  // one-cycle command strobe with captured fields
  typedef struct packed {
    logic valid;
    cmd_t cmd;
  } cmd_strobe_t;

  typedef struct packed {
    logic tx_on;
    logic cw_on;
    logic inhibited;
  } tx_state_t;

  typedef struct packed {
    logic      clip_seen;
    logic      goodlvl_seen;
    clip_cnt_t clip_count;
  } rx_state_t;

  // 40-bit response word
  typedef struct packed {
    cmd_addr_t addr;
    logic      tx_on;
    logic      cw_on;
    cmd_data_t data;
  } resp_t;

endpackage
